// ==== design/usb_tx_proto_pkg.sv ====
// #########################################################################
// USB protocol encodings: PID codes and the PID byte union, SYNC byte,
// CRC16 constants, byte source select, packet states, line phases and
// the dp/dm line states
// #########################################################################

`default_nettype none

package usb_tx_proto_pkg;

	// PID type codes, low nibble of the PID byte
	localparam logic [3:0] PID_DATA0 = 4'b0011;
	localparam logic [3:0] PID_DATA1 = 4'b1011;
	localparam logic [3:0] PID_ACK = 4'b0010;
	localparam logic [3:0] PID_NAK = 4'b1010;

	// PID byte as popped, or as check and type nibbles
	typedef union packed
	{
		logic [7:0] raw;
		struct packed
		{
			// Complement of the type
			logic [3:0] pid_check;
			logic [3:0] pid_type;
		} fields;
	} pid_word_t;

	// Seven 0s then a 1 when sent LSB first
	localparam logic [7:0] SYNC_BYTE = 8'h80;

	// x^16 + x^15 + x^2 + 1, bit-reversed for an LSB-first shift
	localparam logic [15:0] CRC16_POLY = 16'hA001;
	localparam logic [15:0] CRC16_INIT = 16'hFFFF;

	// Byte source of the shifter
	typedef enum logic [1:0]
	{
		LOAD_SYNC,
		LOAD_BUFFER,
		LOAD_CRC_LOW,
		LOAD_CRC_HIGH
	} load_sel_t;

	// Packet states, named after the byte on the line
	localparam logic [2:0] ST_IDLE = 3'd0;
	localparam logic [2:0] ST_SYNC = 3'd1;
	localparam logic [2:0] ST_PID = 3'd2;
	localparam logic [2:0] ST_DATA = 3'd3;
	localparam logic [2:0] ST_CRC_LOW = 3'd4;
	localparam logic [2:0] ST_CRC_HIGH = 3'd5;
	localparam logic [2:0] ST_EOP = 3'd6;

	// What the current line bit is
	localparam logic [2:0] PH_IDLE = 3'd0;
	localparam logic [2:0] PH_DATA = 3'd1;
	localparam logic [2:0] PH_STUFF = 3'd2;
	localparam logic [2:0] PH_SE0 = 3'd3;
	localparam logic [2:0] PH_J = 3'd4;

	// Line states as {dp, dm}
	localparam logic [1:0] LINE_J = 2'b10;
	localparam logic [1:0] LINE_K = 2'b01;
	localparam logic [1:0] LINE_SE0 = 2'b00;

endpackage

`default_nettype wire

// ==== design/usb_tx_timing_pkg.sv ====
// #########################################################################
// Full-speed bit timing: clocks per bit, counter widths, bit stuffing
// limit and end-of-packet length
// #########################################################################

`default_nettype none

package usb_tx_timing_pkg;

	// Clocks per line bit
	localparam int unsigned BIT_CLOCKS = 8;
	localparam int unsigned BIT_CNT_W = 3;

	// Run of 1s that forces a stuffed 0
	localparam int unsigned STUFF_LIMIT = 6;
	localparam int unsigned STUFF_CNT_W = 3;

	// SE0 bit times before the closing J
	localparam int unsigned EOP_SE0_BITS = 2;
	localparam int unsigned EOP_CNT_W = 2;

endpackage

`default_nettype wire

// ==== design/usb_tx_controller.sv ====
// #########################################################################
// Packet FSM: SYNC load, PID pop and latch, payload pops, CRC bytes
// for DATA PIDs, then end-of-packet
// #########################################################################

`timescale 1ns/1ns
`default_nettype none

module usb_tx_controller
	import usb_tx_proto_pkg::*;
(
	input wire tb_clk,
	input wire reset,
	input wire transmit_start,
	input wire transmit_empty,
	input wire pid_word_t tx_data,
	input wire byte_sent,
	input wire eop_done,
	output logic read_enable,
	output logic load_enable,
	output load_sel_t load_select,
	output logic tx_enable,
	output logic crc_enable,
	output logic crc_clear,
	output logic create_eop,
	output logic transmitting
);

	logic [2:0] state;
	logic [2:0] state_next;
	logic sync_load;
	logic [3:0] pid_type;
	logic pid_pop;
	logic crc_pid;

	// End of SYNC with a PID waiting
	assign pid_pop = (state == ST_SYNC) && byte_sent && !transmit_empty;

	// DATA0 and DATA1 carry a CRC
	assign crc_pid = (pid_type == PID_DATA0) || (pid_type == PID_DATA1);

	assign transmitting = (state != ST_IDLE);
	// Bit timer starts one clock after the SYNC load
	assign tx_enable = (state != ST_IDLE) && !sync_load;
	// Only payload bits go into the CRC
	assign crc_enable = (state == ST_DATA);
	assign crc_clear = sync_load;

	always_comb
	begin
		state_next = state;
		load_enable = 1'b0;
		load_select = LOAD_BUFFER;
		read_enable = 1'b0;
		create_eop = 1'b0;
		case (state)
			ST_IDLE:
				if (transmit_start)
					state_next = ST_SYNC;
			ST_SYNC:
			begin
				if (sync_load)
				begin
					load_enable = 1'b1;
					load_select = LOAD_SYNC;
				end
				else if (pid_pop)
				begin
					load_enable = 1'b1;
					read_enable = 1'b1;
					state_next = ST_PID;
				end
				// Empty source, close the packet
				else if (byte_sent)
				begin
					create_eop = 1'b1;
					state_next = ST_EOP;
				end
			end
			ST_PID, ST_DATA:
			begin
				if (byte_sent && !transmit_empty)
				begin
					load_enable = 1'b1;
					read_enable = 1'b1;
					state_next = ST_DATA;
				end
				else if (byte_sent && crc_pid)
				begin
					load_enable = 1'b1;
					load_select = LOAD_CRC_LOW;
					state_next = ST_CRC_LOW;
				end
				else if (byte_sent)
				begin
					create_eop = 1'b1;
					state_next = ST_EOP;
				end
			end
			ST_CRC_LOW:
				if (byte_sent)
				begin
					load_enable = 1'b1;
					load_select = LOAD_CRC_HIGH;
					state_next = ST_CRC_HIGH;
				end
			ST_CRC_HIGH:
				if (byte_sent)
				begin
					create_eop = 1'b1;
					state_next = ST_EOP;
				end
			ST_EOP:
			begin
				// Held through SE0 and J
				create_eop = 1'b1;
				if (eop_done)
					state_next = ST_IDLE;
			end
			default:
				state_next = ST_IDLE;
		endcase
	end

	always_ff @(posedge tb_clk)
	begin
		if (reset)
		begin
			state <= ST_IDLE;
			sync_load <= 1'b0;
		end
		else
		begin
			state <= state_next;
			// One-cycle SYNC load right after start
			sync_load <= (state == ST_IDLE) && transmit_start;
		end
	end

	// PID type kept for the CRC decision
	always_ff @(posedge tb_clk)
	begin
		if (pid_pop)
			pid_type <= tx_data.fields.pid_type;
	end

endmodule

`default_nettype wire

// ==== design/usb_tx_bit_timer.sv ====
// #########################################################################
// Bit-period counter for bit_strobe and data-bit counter for byte_sent
// #########################################################################

`timescale 1ns/1ns
`default_nettype none

module usb_tx_bit_timer
	import usb_tx_timing_pkg::*;
(
	input wire tb_clk,
	input wire reset,
	input wire tx_enable,
	input wire data_bit_sent,
	output logic bit_strobe,
	output logic byte_sent
);

	logic [BIT_CNT_W-1:0] period_cnt;
	logic [2:0] data_cnt;

	// Last clock of each line bit
	assign bit_strobe = tx_enable && (period_cnt == BIT_CNT_W'(BIT_CLOCKS - 1));

	// Eighth data bit leaving, stuffed bits never counted
	assign byte_sent = data_bit_sent && (data_cnt == 3'd7);

	always_ff @(posedge tb_clk)
	begin
		if (reset || !tx_enable)
		begin
			period_cnt <= '0;
			data_cnt <= '0;
		end
		else
		begin
			// Wrap at the strobe
			if (bit_strobe)
				period_cnt <= '0;
			else
				period_cnt <= period_cnt + 1'b1;
			// Wraps to 0 after each byte
			if (data_bit_sent)
				data_cnt <= data_cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== design/usb_tx_shifter.sv ====
// #########################################################################
// Byte source mux, LSB-first shift register, bit stuffer, NRZI encoder
// and end-of-packet line driver
// #########################################################################

`timescale 1ns/1ns
`default_nettype none

module usb_tx_shifter
	import usb_tx_proto_pkg::*;
	import usb_tx_timing_pkg::*;
(
	input wire tb_clk,
	input wire reset,
	input wire bit_strobe,
	input wire load_enable,
	input wire load_sel_t load_select,
	input wire [7:0] tx_data,
	input wire [15:0] crc_remainder,
	input wire create_eop,
	output logic dp,
	output logic dm,
	output logic data_bit,
	output logic data_bit_sent,
	output logic eop_done
);

	logic [7:0] shift_reg;
	logic [7:0] shift_next;
	logic [7:0] load_byte;
	logic [2:0] phase;
	logic [2:0] phase_next;
	logic nrzi_j;
	logic nrzi_next;
	logic [STUFF_CNT_W-1:0] ones_cnt;
	logic [STUFF_CNT_W-1:0] ones_next;
	logic [STUFF_CNT_W-1:0] run_next;
	logic [EOP_CNT_W-1:0] eop_cnt;
	logic [EOP_CNT_W-1:0] eop_next;
	logic bit_leaves;
	logic need_stuff;

	always_comb
	begin
		load_byte = SYNC_BYTE;
		case (load_select)
			LOAD_SYNC: load_byte = SYNC_BYTE;
			LOAD_BUFFER: load_byte = tx_data;
			LOAD_CRC_LOW: load_byte = crc_remainder[7:0];
			LOAD_CRC_HIGH: load_byte = crc_remainder[15:8];
		endcase
	end

	// Bit on the line, counted only when it is not a stuffed 0
	assign data_bit = shift_reg[0];
	assign data_bit_sent = bit_strobe && (phase == PH_DATA);
	// End of the closing J
	assign eop_done = bit_strobe && (phase == PH_J);

	// A load or a strobe ends the current data or stuffed bit
	assign bit_leaves = load_enable
		|| (bit_strobe && ((phase == PH_DATA) || (phase == PH_STUFF)));

	// Run of 1s once the current bit has left
	assign run_next = ((phase == PH_DATA) && shift_reg[0]) ? ones_cnt + 1'b1 : '0;
	assign need_stuff = (run_next == STUFF_CNT_W'(STUFF_LIMIT));

	always_comb
	begin
		shift_next = shift_reg;
		phase_next = phase;
		nrzi_next = nrzi_j;
		ones_next = ones_cnt;
		eop_next = eop_cnt;
		if (bit_leaves)
		begin
			ones_next = run_next;
			// Stuffed bit keeps the pending data bit
			if (load_enable)
				shift_next = load_byte;
			else if (phase == PH_DATA)
				shift_next = {1'b0, shift_reg[7:1]};
			if (need_stuff)
			begin
				phase_next = PH_STUFF;
				nrzi_next = ~nrzi_j;
			end
			// Last bit gone, start SE0
			else if (create_eop)
			begin
				phase_next = PH_SE0;
				eop_next = '0;
			end
			else
			begin
				phase_next = PH_DATA;
				// NRZI, toggle on 0
				nrzi_next = nrzi_j ^ ~shift_next[0];
			end
		end
		else if (bit_strobe && (phase == PH_SE0))
		begin
			if (eop_cnt == EOP_CNT_W'(EOP_SE0_BITS - 1))
			begin
				phase_next = PH_J;
				nrzi_next = 1'b1;
			end
			else
				eop_next = eop_cnt + 1'b1;
		end
		else if (bit_strobe && (phase == PH_J))
			phase_next = PH_IDLE;
	end

	always_ff @(posedge tb_clk)
	begin
		if (reset)
		begin
			phase <= PH_IDLE;
			nrzi_j <= 1'b1;
			ones_cnt <= '0;
			eop_cnt <= '0;
		end
		else
		begin
			phase <= phase_next;
			nrzi_j <= nrzi_next;
			ones_cnt <= ones_next;
			eop_cnt <= eop_next;
		end
	end

	always_ff @(posedge tb_clk)
		shift_reg <= shift_next;

	// Idle and NRZI level share the J/K drive
	assign {dp, dm} = (phase == PH_SE0) ? LINE_SE0 : (nrzi_j ? LINE_J : LINE_K);

endmodule

`default_nettype wire

// ==== design/usb_tx_crc16.sv ====
// #########################################################################
// Serial CRC16 over the payload bits, remainder output inverted
// #########################################################################

`timescale 1ns/1ns
`default_nettype none

module usb_tx_crc16
	import usb_tx_proto_pkg::*;
(
	input wire tb_clk,
	input wire reset,
	input wire crc_clear,
	input wire crc_enable,
	input wire data_bit,
	input wire data_bit_sent,
	output logic [15:0] crc_remainder
);

	logic [15:0] crc_q;
	logic [15:0] crc_d;
	logic feedback;

	assign feedback = crc_q[0] ^ data_bit;

	// Right shift, LSB-first data
	always_comb
	begin
		crc_d = crc_q;
		if (crc_enable && data_bit_sent)
			crc_d = {1'b0, crc_q[15:1]} ^ (feedback ? CRC16_POLY : 16'h0000);
	end

	always_ff @(posedge tb_clk)
	begin
		if (reset || crc_clear)
			crc_q <= CRC16_INIT;
		else
			crc_q <= crc_d;
	end

	// Includes the bit leaving now, the low byte loads on that same edge
	assign crc_remainder = ~crc_d;

endmodule

`default_nettype wire

// ==== design/usb_tx.sv ====
// #########################################################################
// USB full-speed packet transmitter top: controller, bit timer,
// shifter and CRC16
// #########################################################################

`timescale 1ns/1ns
`default_nettype none

module usb_tx
	import usb_tx_proto_pkg::*;
(
	input wire tb_clk,
	input wire reset,
	input wire transmit_start,
	input wire transmit_empty,
	input wire [7:0] tx_data,
	output logic read_enable,
	output logic dp,
	output logic dm,
	output logic transmitting
);

	pid_word_t pid_word;
	load_sel_t load_select;
	logic load_enable;
	logic tx_enable;
	logic crc_enable;
	logic crc_clear;
	logic create_eop;
	logic bit_strobe;
	logic byte_sent;
	logic data_bit;
	logic data_bit_sent;
	logic eop_done;
	logic [15:0] crc_remainder;

	// Source byte seen as a PID by the controller
	assign pid_word.raw = tx_data;

	usb_tx_controller u_controller
	(
		.tb_clk(tb_clk),
		.reset(reset),
		.transmit_start(transmit_start),
		.transmit_empty(transmit_empty),
		.tx_data(pid_word),
		.byte_sent(byte_sent),
		.eop_done(eop_done),
		.read_enable(read_enable),
		.load_enable(load_enable),
		.load_select(load_select),
		.tx_enable(tx_enable),
		.crc_enable(crc_enable),
		.crc_clear(crc_clear),
		.create_eop(create_eop),
		.transmitting(transmitting)
	);

	usb_tx_bit_timer u_bit_timer
	(
		.tb_clk(tb_clk),
		.reset(reset),
		.tx_enable(tx_enable),
		.data_bit_sent(data_bit_sent),
		.bit_strobe(bit_strobe),
		.byte_sent(byte_sent)
	);

	usb_tx_shifter u_shifter
	(
		.tb_clk(tb_clk),
		.reset(reset),
		.bit_strobe(bit_strobe),
		.load_enable(load_enable),
		.load_select(load_select),
		.tx_data(tx_data),
		.crc_remainder(crc_remainder),
		.create_eop(create_eop),
		.dp(dp),
		.dm(dm),
		.data_bit(data_bit),
		.data_bit_sent(data_bit_sent),
		.eop_done(eop_done)
	);

	usb_tx_crc16 u_crc16
	(
		.tb_clk(tb_clk),
		.reset(reset),
		.crc_clear(crc_clear),
		.crc_enable(crc_enable),
		.data_bit(data_bit),
		.data_bit_sent(data_bit_sent),
		.crc_remainder(crc_remainder)
	);

endmodule

`default_nettype wire

// ==== bench/tb_clock_gen.sv ====
// ##########################################################################
// Testbench clock (40 ns period) and synchronous reset for 16 cycles
// ##########################################################################

`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen
(
	output logic tb_clk,
	output logic reset
);

	localparam int HALF_PERIOD = 20;
	localparam int RESET_CYCLES = 16;

	initial
	begin
		tb_clk = 1'b0;
		forever
			#(HALF_PERIOD) tb_clk = ~tb_clk;
	end

	// Released just after a rising edge, like every other input
	initial
	begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge tb_clk);
		#2;
		reset = 1'b0;
	end

endmodule

`default_nettype wire

// ==== bench/usb_tx_assert.sv ====
// ##########################################################################
// Concurrent checks on the usb_tx line and byte source strobes,
// bound into the usb_tx top level
// ##########################################################################

`timescale 1ns/1ns
`default_nettype none

module usb_tx_assert
(
	input wire tb_clk,
	input wire reset,
	input wire dp,
	input wire dm,
	input wire read_enable,
	input wire transmit_empty,
	input wire load_enable,
	input wire transmitting
);

	// Only J, K or SE0 on the line
	line_legal: assert property (@(posedge tb_clk) disable iff (reset) !(dp && dm))
		else $error("dp and dm both high");

	// Never pop an empty source
	pop_not_empty: assert property (@(posedge tb_clk) disable iff (reset)
		read_enable |-> !transmit_empty)
		else $error("read_enable while transmit_empty is high");

	// Shifter loads belong to a packet
	load_in_packet: assert property (@(posedge tb_clk) disable iff (reset)
		load_enable |-> transmitting)
		else $error("load_enable outside a packet");

endmodule

bind usb_tx usb_tx_assert u_assert
(
	.tb_clk(tb_clk),
	.reset(reset),
	.dp(dp),
	.dm(dm),
	.read_enable(read_enable),
	.transmit_empty(transmit_empty),
	.load_enable(load_enable),
	.transmitting(transmitting)
);

`default_nettype wire

// ==== bench/tb_usb_tx.sv ====
// ##########################################################################
// Testbench for usb_tx with a byte source model, NRZI line decoder and
// unstuffing, reference CRC16, packet table run in a loop, checks and watchdog
// ##########################################################################

`timescale 1ns/1ns
`default_nettype none

module tb_usb_tx
	import usb_tx_proto_pkg::*;
	import usb_tx_timing_pkg::*;
();

	localparam int CLK_PERIOD = 40;
	localparam int NUM_ROWS = 8;
	localparam logic [31:0] RANDOM_SEED = 32'he62f_8ba9;

	// Packet table with one column per array
	// pid type | payload length | random payload | fill byte | CRC expected
	localparam logic [3:0] ROW_PID [NUM_ROWS] = '{PID_ACK, PID_NAK, PID_DATA0, PID_DATA1,
		PID_DATA0, PID_DATA1, PID_DATA0, PID_DATA1};
	localparam int ROW_LEN [NUM_ROWS] = '{0, 0, 4, 8, 1, 6, 0, 3};
	localparam bit ROW_RANDOM [NUM_ROWS] = '{0, 0, 1, 1, 1, 0, 0, 1};
	localparam logic [7:0] ROW_FILL [NUM_ROWS] = '{8'h00, 8'h00, 8'h00, 8'h00,
		8'h00, 8'hFF, 8'h00, 8'h00};
	localparam bit ROW_CRC [NUM_ROWS] = '{0, 0, 1, 1, 1, 1, 1, 1};

	wire tb_clk;
	wire reset;
	wire read_enable;
	wire dp;
	wire dm;
	wire transmitting;
	logic transmit_start;
	logic transmit_empty;
	logic [7:0] tx_data;

	// Source model and decoder state
	logic [7:0] src_q [$];
	logic [1:0] line_q [$];
	logic [7:0] got_q [$];
	logic pop_now;
	int pop_count;
	int line_bits;
	int max_run;
	int error_count;
	int pass_count;
	int test_count;

	tb_clock_gen u_clock_gen
	(
		.tb_clk(tb_clk),
		.reset(reset)
	);

	usb_tx dut
	(
		.tb_clk(tb_clk),
		.reset(reset),
		.transmit_start(transmit_start),
		.transmit_empty(transmit_empty),
		.tx_data(tx_data),
		.read_enable(read_enable),
		.dp(dp),
		.dm(dm),
		.transmitting(transmitting)
	);

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
		input string msg);
		if (actual !== expected)
		begin
			$display("CHECK FAILED at %0t ns: %s (got %0h, expected %0h)",
				$time, msg, actual, expected);
			error_count++;
		end
	endtask

	// Head of the FWFT buffer or empty
	task automatic drive_source();
		transmit_empty = (src_q.size() == 0);
		tx_data = (src_q.size() == 0) ? 8'h00 : src_q[0];
	endtask

	// Pop decided on the level before the edge
	// Next byte 2 ns after the edge
	always
	begin
		@(negedge tb_clk);
		pop_now = read_enable;
		@(posedge tb_clk);
		#2;
		if (pop_now && src_q.size() > 0)
		begin
			void'(src_q.pop_front());
			pop_count++;
			drive_source();
		end
	end

	// x^16 + x^15 + x^2 + 1 in MSB-first form and reflected at the end
	task automatic reference_crc16(input logic [7:0] data [$], output logic [15:0] remainder);
		logic [15:0] lfsr;
		logic feedback;
		int i;
		int b;
		lfsr = 16'hFFFF;
		for (i = 0; i < data.size(); i++)
			for (b = 0; b < 8; b++)
			begin
				feedback = lfsr[15] ^ data[i][b];
				lfsr = {lfsr[14:0], 1'b0} ^ (feedback ? 16'h8005 : 16'h0000);
			end
		// Wire order is bit-reversed and inverted
		for (b = 0; b < 16; b++)
			remainder[b] = ~lfsr[15 - b];
	endtask

	// Line bits including stuffed 0s with runs carried across bytes
	function automatic int stuffed_length(input logic [7:0] data [$]);
		int count;
		int run;
		int i;
		int b;
		count = 0;
		run = 0;
		for (i = 0; i < data.size(); i++)
			for (b = 0; b < 8; b++)
			begin
				count++;
				run = data[i][b] ? run + 1 : 0;
				if (run == STUFF_LIMIT)
				begin
					count++;
					run = 0;
				end
			end
		return count;
	endfunction

	// NRZI decode and unstuff line_q into got_q then check the EOP tail
	task automatic decode_line();
		logic level;
		logic prev;
		logic bit_val;
		logic [7:0] cur;
		int ones;
		int run;
		int bit_pos;
		int se0_at;
		int i;
		got_q = {};
		prev = 1'b1;
		cur = 8'h00;
		ones = 0;
		run = 0;
		bit_pos = 0;
		se0_at = -1;
		line_bits = 0;
		max_run = 0;
		for (i = 0; i < line_q.size() && se0_at < 0; i++)
		begin
			if (line_q[i] == LINE_SE0)
				se0_at = i;
			else
			begin
				level = (line_q[i] == LINE_J);
				// No level change is a 1
				bit_val = (level == prev);
				prev = level;
				line_bits++;
				run = bit_val ? run + 1 : 0;
				if (run > max_run)
					max_run = run;
				if (ones == STUFF_LIMIT)
				begin
					check_value(bit_val, 0, "stuffed bit after six 1s is not 0");
					ones = 0;
				end
				else
				begin
					ones = bit_val ? ones + 1 : 0;
					cur[bit_pos] = bit_val;
					bit_pos++;
					if (bit_pos == 8)
					begin
						got_q.push_back(cur);
						bit_pos = 0;
					end
				end
			end
		end
		check_value(bit_pos, 0, "partial byte before end of packet");
		check_value(se0_at >= 0, 1, "no SE0 at end of packet");
		// SE0 twice then J before transmitting falls
		if (se0_at >= 0)
		begin
			check_value(line_q.size() - se0_at, 3, "EOP length in bit times");
			if (line_q.size() == se0_at + 3)
			begin
				check_value(line_q[se0_at + 1], LINE_SE0, "second EOP bit not SE0");
				check_value(line_q[se0_at + 2], LINE_J, "EOP does not end with J");
			end
		end
	endtask

	task automatic run_packet(input int row);
		logic [7:0] pid_byte;
		logic [7:0] payload [$];
		logic [7:0] expected [$];
		logic [15:0] crc_ref;
		int errors_before;
		int bit_guard;
		int i;
		errors_before = error_count;
		pid_byte = {~ROW_PID[row], ROW_PID[row]};
		payload = {};
		for (i = 0; i < ROW_LEN[row]; i++)
			payload.push_back(ROW_RANDOM[row] ? 8'($urandom()) : ROW_FILL[row]);
		expected = {SYNC_BYTE, pid_byte};
		foreach (payload[j])
			expected.push_back(payload[j]);
		if (ROW_CRC[row])
		begin
			reference_crc16(payload, crc_ref);
			expected.push_back(crc_ref[7:0]);
			expected.push_back(crc_ref[15:8]);
		end
		// Whole packet in the source before start
		@(posedge tb_clk);
		#2;
		src_q = {pid_byte};
		foreach (payload[j])
			src_q.push_back(payload[j]);
		pop_count = 0;
		drive_source();
		transmit_start = 1'b1;
		@(posedge tb_clk);
		#2;
		transmit_start = 1'b0;
		check_value({dp, dm}, LINE_J, "line left J before the first SYNC bit");
		check_value(transmitting, 1, "transmitting low after the SYNC load");
		// First SYNC bit starts at this edge
		@(posedge tb_clk);
		#2;
		check_value({dp, dm}, LINE_K, "first SYNC bit not on the line 2 clocks after start");
		line_q = {};
		bit_guard = expected.size() * 16 + 16;
		while (bit_guard > 0)
		begin
			repeat (BIT_CLOCKS / 2) @(posedge tb_clk);
			#2;
			if (!transmitting)
				break;
			line_q.push_back({dp, dm});
			repeat (BIT_CLOCKS / 2) @(posedge tb_clk);
			bit_guard--;
		end
		check_value(bit_guard > 0, 1, "transmitting did not fall after the packet");
		check_value({dp, dm}, LINE_J, "line not J after the packet");
		decode_line();
		check_value(line_bits, stuffed_length(expected), "line bits vs stuffed length");
		check_value(max_run <= STUFF_LIMIT, 1, "run of 1s longer than six on the line");
		check_value(got_q.size(), expected.size(), "decoded byte count");
		for (i = 0; i < got_q.size() && i < expected.size(); i++)
			check_value(got_q[i], expected[i], $sformatf("decoded byte %0d", i));
		check_value(pop_count, ROW_LEN[row] + 1, "read_enable pulses vs bytes loaded");
		check_value(src_q.size(), 0, "source not drained");
		// Empty DATA payload gives a zero CRC
		if (ROW_CRC[row] && ROW_LEN[row] == 0 && got_q.size() == 4)
			check_value({got_q[3], got_q[2]}, 16'h0000, "CRC of empty payload");
		test_count++;
		if (error_count == errors_before)
			pass_count++;
		$display("test %0d: pid %02h, %0d payload bytes, %0d line bits: %s", row, pid_byte,
			ROW_LEN[row], line_bits, (error_count == errors_before) ? "ok" : "FAIL");
		repeat (4) @(posedge tb_clk);
	endtask

	// Limit from the table with doubled bits for worst-case stuffing
	function automatic longint unsigned watchdog_limit();
		longint unsigned cycles;
		int r;
		cycles = 300;
		for (r = 0; r < NUM_ROWS; r++)
			cycles += longint'(((ROW_LEN[r] + 4) * 16 + 3) * BIT_CLOCKS + 40);
		return cycles * CLK_PERIOD;
	endfunction

	initial
	begin
		longint unsigned limit_ns;
		limit_ns = watchdog_limit();
		#(limit_ns);
		$display("Timeout: packets did not finish within %0d ns", limit_ns);
		$display("tests failed");
		$finish;
	end

	initial
	begin
		int row;
		int errors_before;
		void'($urandom(RANDOM_SEED));
		transmit_start = 1'b0;
		transmit_empty = 1'b1;
		tx_data = 8'h00;
		pop_now = 1'b0;
		pop_count = 0;
		error_count = 0;
		pass_count = 0;
		test_count = 0;
		@(negedge reset);
		@(posedge tb_clk);
		#2;
		// Idle line and strobes after reset
		errors_before = error_count;
		check_value({dp, dm}, LINE_J, "line not J after reset");
		check_value(transmitting, 0, "transmitting high after reset");
		check_value(read_enable, 0, "read_enable high after reset");
		test_count++;
		if (error_count == errors_before)
			pass_count++;
		$display("test reset: idle state: %s", (error_count == errors_before) ? "ok" : "FAIL");
		for (row = 0; row < NUM_ROWS; row++)
			run_packet(row);
		$display("%0d tests run, %0d passed, %0d checks wrong",
			test_count, pass_count, error_count);
		if (error_count == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== usb_tx.f ====
design/usb_tx_proto_pkg.sv
design/usb_tx_timing_pkg.sv
design/usb_tx_controller.sv
design/usb_tx_bit_timer.sv
design/usb_tx_shifter.sv
design/usb_tx_crc16.sv
design/usb_tx.sv
bench/tb_clock_gen.sv
bench/usb_tx_assert.sv
bench/tb_usb_tx.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the usb_tx testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_usb_tx \
	-f usb_tx.f -o sim_usb_tx || { echo "Verilator build failed"; exit 1; }
sim_out=$(./obj_dir/sim_usb_tx)
echo "$sim_out"
# Pass only when the exact pass line is in the output
echo "$sim_out" | grep -qx "all tests passed" && exit 0 || exit 1
